//--- common/matmul_pkg.sv
package matmul_pkg;

  // edge length of the PE grid, rows and columns alike
  parameter int dim = 4;

  // bits per matrix element
  parameter int elem_w = 16;

  // accumulator is twice the element width
  parameter int acc_w = 2 * elem_w;

  // one unsigned matrix element
  typedef logic [elem_w-1:0] elem_t;

  // per-cell running sum of products
  typedef logic [acc_w-1:0] acc_t;

  // dim lanes side by side, lane 0 in the low bits
  // carries an operand word (A column + B row) or one C row
  typedef elem_t [dim-1:0] row_t;

endpackage

//--- design/operand_skew.sv
`timescale 1ns/100ps

module operand_skew (
  input  logic             clk,
  input  logic             reset,
  input  logic             accept,
  input  matmul_pkg::row_t in_a_col,
  input  matmul_pkg::row_t in_b_row,
  output matmul_pkg::row_t a_lanes,
  output matmul_pkg::row_t b_lanes
);
  import matmul_pkg::*;

  // zeros outside the operand window
  row_t a_gated;
  row_t b_gated;

  assign a_gated = accept ? in_a_col : '0;
  assign b_gated = accept ? in_b_row : '0;

  for (genvar i = 0; i < dim; i++) begin : g_lane
    if (i == 0) begin : g_direct
      // lane 0 enters the grid in the accept cycle
      assign a_lanes[i] = a_gated[i];
      assign b_lanes[i] = b_gated[i];
    end else begin : g_delay
      // A and B of one lane move together, [0] = A, [1] = B
      elem_t [1:0] pipe [i];

      always_ff @(posedge clk) begin
        if (reset) begin
          for (int s = 0; s < i; s++) begin
            pipe[s] <= '0;
          end
        end else begin
          pipe[0] <= {b_gated[i], a_gated[i]};
          for (int s = 1; s < i; s++) begin
            pipe[s] <= pipe[s-1];
          end
        end
      end

      // tap after i stages
      assign a_lanes[i] = pipe[i-1][0];
      assign b_lanes[i] = pipe[i-1][1];
    end
  end

endmodule

//--- systolic_array/processing_element.sv
`timescale 1ns/100ps

module processing_element (
  input  logic              clk,
  input  logic              reset,
  input  logic              clear,
  input  matmul_pkg::elem_t in_a,
  input  matmul_pkg::elem_t in_b,
  output matmul_pkg::elem_t out_a,
  output matmul_pkg::elem_t out_b,
  output matmul_pkg::elem_t out_c
);
  import matmul_pkg::*;

  acc_t           acc;
  acc_t           product;
  logic [acc_w:0] sum;

  // element product always fits the accumulator
  assign product = acc_t'(in_a) * acc_t'(in_b);
  // top bit flags a carry out of the accumulator
  assign sum = {1'b0, acc} + {1'b0, product};

  always_ff @(posedge clk) begin
    if (reset) begin
      out_a <= '0;
      out_b <= '0;
      acc   <= '0;
    end else begin
      // neighbours see the operands one cycle later
      out_a <= in_a;
      out_b <= in_b;
      if (clear) begin
        acc <= '0;
      end else if (sum[acc_w]) begin
        // pin at max so a wrapped sum never looks small
        acc <= '1;
      end else begin
        acc <= sum[acc_w-1:0];
      end
    end
  end

  // anything above elem_w bits clips to all ones
  assign out_c = (|acc[acc_w-1:elem_w]) ? '1 : acc[elem_w-1:0];

endmodule

//--- systolic_array/systolic_array.sv
`timescale 1ns/100ps

module systolic_array (
  input  logic             clk,
  input  logic             reset,
  input  logic             clear,
  input  matmul_pkg::row_t a_lanes,
  input  matmul_pkg::row_t b_lanes,
  output matmul_pkg::row_t c_rows [matmul_pkg::dim]
);
  import matmul_pkg::*;

  // operands seen by cell [i][j]
  elem_t a_in   [dim][dim];
  elem_t b_in   [dim][dim];
  // registered pass-through of cell [i][j]
  elem_t a_out  [dim][dim];
  elem_t b_out  [dim][dim];
  // saturated result of cell [i][j]
  elem_t c_cell [dim][dim];

  for (genvar i = 0; i < dim; i++) begin : g_row
    for (genvar j = 0; j < dim; j++) begin : g_col
      // A enters on the left edge and moves right
      if (j == 0) begin : g_a_edge
        assign a_in[i][j] = a_lanes[i];
      end else begin : g_a_chain
        assign a_in[i][j] = a_out[i][j-1];
      end

      // B enters on the top edge and moves down
      if (i == 0) begin : g_b_edge
        assign b_in[i][j] = b_lanes[j];
      end else begin : g_b_chain
        assign b_in[i][j] = b_out[i-1][j];
      end

      processing_element pe_i (
        .clk   (clk),
        .reset (reset),
        .clear (clear),
        .in_a  (a_in[i][j]),
        .in_b  (b_in[i][j]),
        .out_a (a_out[i][j]),
        .out_b (b_out[i][j]),
        .out_c (c_cell[i][j])
      );
    end

    // column j lands in lane j of the row
    always_comb begin
      for (int j = 0; j < dim; j++) begin
        c_rows[i][j] = c_cell[i][j];
      end
    end
  end

endmodule

//--- design/tile_sequencer.sv
`timescale 1ns/100ps

module tile_sequencer (
  input  logic             clk,
  input  logic             reset,
  input  logic             in_valid,
  input  logic             tile_room,
  input  matmul_pkg::row_t c_rows [matmul_pkg::dim],
  output logic             ready,
  output logic             accept,
  output logic             array_clear,
  output logic             push,
  output matmul_pkg::row_t push_row
);
  import matmul_pkg::*;

  // row i is final after count 2*dim-2+i, captured one count later
  localparam int first_capture = 2 * dim - 1;
  localparam int last_capture  = 3 * dim - 2;
  // push of the last row, also the clear cycle
  localparam int last_count    = 3 * dim - 1;
  localparam int cnt_w         = $clog2(last_count + 1);
  localparam int row_w         = $clog2(dim);

  logic             busy;
  logic [cnt_w-1:0] count;
  logic             capture;
  logic [cnt_w-1:0] cap_offset;

  // new tile only when idle and the buffer has room for a whole tile
  // busy runs through the last push, so tile_room already counts that row
  assign ready = !busy && tile_room;

  // word 0 needs ready, words 1..dim-1 follow unconditionally
  assign accept = busy ? (count < cnt_w'(dim)) : (ready && in_valid);

  // accumulators zeroed in idle cycles and after the last capture
  assign array_clear = busy ? (count == cnt_w'(last_count)) : !accept;

  assign capture    = busy && (count >= cnt_w'(first_capture)) &&
                      (count <= cnt_w'(last_capture));
  assign cap_offset = count - cnt_w'(first_capture);

  // count 0 is the idle accept cycle, busy holds counts 1..last_count
  always_ff @(posedge clk) begin
    if (reset) begin
      busy  <= 1'b0;
      count <= '0;
    end else if (!busy) begin
      if (accept) begin
        busy  <= 1'b1;
        count <= cnt_w'(1);
      end
    end else if (count == cnt_w'(last_count)) begin
      busy  <= 1'b0;
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

  // one row per cycle, row 0 first
  always_ff @(posedge clk) begin
    if (reset) begin
      push <= 1'b0;
    end else begin
      push <= capture;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      push_row <= c_rows[cap_offset[row_w-1:0]];
    end
  end

endmodule

//--- design/result_buffer.sv
`timescale 1ns/100ps

module result_buffer #(
  parameter int buffer_rows  = 8,
  parameter int sink_credits = 2
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             push,
  input  logic             credit_return,
  input  matmul_pkg::row_t push_row,
  output logic             tile_room,
  output logic             out_valid,
  output matmul_pkg::row_t out_row
);
  import matmul_pkg::*;

  localparam int ptr_w    = (buffer_rows > 1) ? $clog2(buffer_rows) : 1;
  localparam int fill_w   = $clog2(buffer_rows + 1);
  localparam int credit_w = $clog2(sink_credits + 1);

  row_t                mem [buffer_rows];
  logic [ptr_w-1:0]    wr_ptr;
  logic [ptr_w-1:0]    rd_ptr;
  logic [fill_w-1:0]   fill;
  logic [credit_w-1:0] credits;
  logic                pop;

  // circular wrap, depth need not be a power of two
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    return (p == ptr_w'(buffer_rows - 1)) ? '0 : p + 1'b1;
  endfunction

  // a row leaves only with data queued and a credit in hand
  assign out_valid = (fill != '0) && (credits != '0);
  assign pop       = out_valid;
  assign out_row   = mem[rd_ptr];

  // space for one full tile of rows
  assign tile_room = fill <= fill_w'(buffer_rows - dim);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_row;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // push and pop together leave fill unchanged
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  // sink starts with sink_credits slots
  // a send and a returned credit may share a cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= credit_w'(sink_credits);
    end else begin
      case ({credit_return, pop})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

//--- design/matmul_top.sv
`timescale 1ns/100ps

module matmul_top #(
  parameter int buffer_rows  = 8,
  parameter int sink_credits = 2
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             in_valid,
  input  logic             credit_return,
  input  matmul_pkg::row_t in_a_col,
  input  matmul_pkg::row_t in_b_row,
  output logic             ready,
  output logic             out_valid,
  output matmul_pkg::row_t out_row
);
  import matmul_pkg::*;

  logic accept;
  logic array_clear;
  logic push;
  logic tile_room;
  row_t a_lanes;
  row_t b_lanes;
  row_t push_row;
  // saturated C rows straight from the grid
  row_t c_rows [dim];

  // lane i delayed by i cycles into the grid edge
  operand_skew skew_i (
    .clk      (clk),
    .reset    (reset),
    .accept   (accept),
    .in_a_col (in_a_col),
    .in_b_row (in_b_row),
    .a_lanes  (a_lanes),
    .b_lanes  (b_lanes)
  );

  systolic_array array_i (
    .clk     (clk),
    .reset   (reset),
    .clear   (array_clear),
    .a_lanes (a_lanes),
    .b_lanes (b_lanes),
    .c_rows  (c_rows)
  );

  // owns the tile timing, one tile in flight
  tile_sequencer seq_i (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .tile_room   (tile_room),
    .c_rows      (c_rows),
    .ready       (ready),
    .accept      (accept),
    .array_clear (array_clear),
    .push        (push),
    .push_row    (push_row)
  );

  // credit link toward the sink
  result_buffer #(
    .buffer_rows  (buffer_rows),
    .sink_credits (sink_credits)
  ) buffer_i (
    .clk           (clk),
    .reset         (reset),
    .push          (push),
    .credit_return (credit_return),
    .push_row      (push_row),
    .tile_room     (tile_room),
    .out_valid     (out_valid),
    .out_row       (out_row)
  );

endmodule

//--- dv/matmul_tb.sv
`timescale 1ns/100ps

module matmul_tb;
  import matmul_pkg::*;

  localparam int n_tests     = 8;
  localparam int credits     = 2;
  localparam int max_cycles  = 60 * n_tests + 200;
  // sink modes
  localparam int mode_always = 0;
  localparam int mode_random = 1;
  localparam int mode_hold   = 2;

  logic clk;
  logic reset;
  logic in_valid;
  logic credit_return;
  row_t in_a_col;
  row_t in_b_row;
  logic ready;
  logic out_valid;
  row_t out_row;

  // stimulus table
  string test_name    [n_tests];
  elem_t mat_a        [n_tests][dim][dim];
  elem_t mat_b        [n_tests][dim][dim];
  int    sink_mode    [n_tests];
  int    hold_cycles  [n_tests];
  bit    back_to_back [n_tests];
  int    test_errs    [n_tests];

  // rows still owed by the DUT, oldest first
  row_t exp_rows  [$];
  int   exp_test  [$];
  int   exp_index [$];

  integer seed;
  int     mode;
  int     hold_left;
  int     hold_test;
  int     held_rows;
  int     owed;
  int     host_test;
  int     passed;
  int     failed;
  int     errors;
  int     stray_rows;
  int     cycles;

  matmul_top dut_i (
    .clk           (clk),
    .reset         (reset),
    .in_valid      (in_valid),
    .credit_return (credit_return),
    .in_a_col      (in_a_col),
    .in_b_row      (in_b_row),
    .ready         (ready),
    .out_valid     (out_valid),
    .out_row       (out_row)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // C[i][j] = sum over k of A[i][k] * B[k][j], clipped to 16 bits
  function automatic row_t expected_row(input int t, input int i);
    row_t            r;
    longint unsigned sum;
    for (int j = 0; j < dim; j++) begin
      sum = 0;
      for (int k = 0; k < dim; k++) begin
        sum += longint'(mat_a[t][i][k]) * longint'(mat_b[t][k][j]);
      end
      r[j] = (sum > 64'hffff) ? 16'hffff : sum[15:0];
    end
    return r;
  endfunction

  task automatic fill_random(input int t, input elem_t mask);
    for (int i = 0; i < dim; i++) begin
      for (int j = 0; j < dim; j++) begin
        mat_a[t][i][j] = elem_t'($random(seed)) & mask;
        mat_b[t][i][j] = elem_t'($random(seed)) & mask;
      end
    end
  endtask

  task automatic set_entry(input int t, input string name, input int m, input int hold,
                           input bit b2b);
    test_name[t]    = name;
    sink_mode[t]    = m;
    hold_cycles[t]  = hold;
    back_to_back[t] = b2b;
    test_errs[t]    = 0;
  endtask

  task automatic build_table();
    set_entry(0, "identity", mode_always, 0, 1'b0);
    for (int i = 0; i < dim; i++) begin
      for (int j = 0; j < dim; j++) begin
        mat_a[0][i][j] = (i == j) ? 16'd1 : 16'd0;
        mat_b[0][i][j] = 16'h1000 * (i + 1) + 16'h0011 * j + 16'd3;
      end
    end
    set_entry(1, "random_small", mode_random, 0, 1'b0);
    fill_random(1, 16'h00ff);
    // row 0 of A and column 3 of B overflow, the rest stays exact
    set_entry(2, "saturation", mode_always, 0, 1'b0);
    for (int i = 0; i < dim; i++) begin
      for (int j = 0; j < dim; j++) begin
        mat_a[2][i][j] = (i == 0) ? 16'hc000 : elem_t'(i + j);
        mat_b[2][i][j] = (j == 3) ? 16'hff00 : elem_t'(i + j + 1);
      end
    end
    // two tiles queued while the sink holds its credits
    set_entry(3, "credit_hold_a", mode_hold, 40, 1'b1);
    fill_random(3, 16'h00ff);
    set_entry(4, "credit_hold_b", mode_always, 0, 1'b0);
    fill_random(4, 16'h00ff);
    set_entry(5, "back_to_back_0", mode_random, 0, 1'b1);
    fill_random(5, 16'h00ff);
    set_entry(6, "back_to_back_1", mode_random, 0, 1'b1);
    fill_random(6, 16'h00ff);
    set_entry(7, "back_to_back_2", mode_random, 0, 1'b0);
    fill_random(7, 16'h00ff);
  endtask

  // four words on consecutive cycles, word 0 held until ready
  task automatic send_tile(input int t);
    row_t a_word;
    row_t b_word;
    for (int i = 0; i < dim; i++) begin
      exp_rows.push_back(expected_row(t, i));
      exp_test.push_back(t);
      exp_index.push_back(i);
    end
    for (int k = 0; k < dim; k++) begin
      for (int l = 0; l < dim; l++) begin
        a_word[l] = mat_a[t][l][k];
        b_word[l] = mat_b[t][k][l];
      end
      @(posedge clk);
      in_valid <= 1'b1;
      in_a_col <= a_word;
      in_b_row <= b_word;
      if (k == 0) begin
        host_test = t;
        mode <= sink_mode[t];
        if (sink_mode[t] == mode_hold) begin
          hold_left <= hold_cycles[t];
          hold_test = t;
        end
        @(negedge clk);
        while (!ready) @(negedge clk);
      end
    end
    if (!back_to_back[t]) begin
      @(posedge clk);
      in_valid <= 1'b0;
      while (exp_rows.size() != 0 || owed != 0) @(negedge clk);
    end
  endtask

  // sink, one credit per taken row starting the cycle after
  always @(posedge clk) begin
    credit_return <= 1'b0;
    if (hold_left > 0) begin
      hold_left <= hold_left - 1;
    end else if (owed > 0 && (mode != mode_random || ($random(seed) & 1))) begin
      credit_return <= 1'b1;
      owed = owed - 1;
    end
  end

  // row monitor, sampled mid cycle
  always @(negedge clk) begin
    int t;
    int idx;
    if (!reset && out_valid) begin
      owed = owed + 1;
      if (exp_rows.size() == 0) begin
        $display("%0t: a row arrived with no tile waiting for it", $time);
        stray_rows++;
      end else begin
        t   = exp_test.pop_front();
        idx = exp_index.pop_front();
        if (out_row !== exp_rows[0]) begin
          $display("[FAIL] %0t test %s row %0d expected %h got %h", $time, test_name[t], idx,
                   exp_rows[0], out_row);
          test_errs[t]++;
          errors++;
        end
        void'(exp_rows.pop_front());
        if (idx == dim - 1) begin
          if (test_errs[t] == 0) begin
            $display("test %s: pass", test_name[t]);
            passed++;
          end else begin
            $display("test %s: %0d errors", test_name[t], test_errs[t]);
            failed++;
          end
        end
      end
      if (hold_left > 0) begin
        held_rows++;
        if (held_rows > credits) begin
          $display("[FAIL] %0t test %s: %0d rows sent while credits held", $time,
                   test_name[hold_test], held_rows);
          test_errs[hold_test]++;
          errors++;
        end
      end
    end
    // last held cycle, both tiles should be queued by now
    if (hold_left == 1 && hold_test >= 0) begin
      if (ready) begin
        $display("[FAIL] %0t test %s: ready expected 0 got 1 with two tiles queued", $time,
                 test_name[hold_test]);
        test_errs[hold_test]++;
        errors++;
      end
    end
  end

  // run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      if (exp_test.size() != 0) begin
        $display("timeout: test %s still waiting for its rows", test_name[exp_test[0]]);
      end else begin
        $display("timeout: test %s never got its tile accepted", test_name[host_test]);
      end
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    seed          = 32'hed732c9f;
    reset         = 1'b1;
    in_valid      = 1'b0;
    credit_return = 1'b0;
    in_a_col      = '0;
    in_b_row      = '0;
    mode          = mode_always;
    hold_left     = 0;
    hold_test     = -1;
    held_rows     = 0;
    owed          = 0;
    host_test     = 0;
    passed        = 0;
    failed        = 0;
    errors        = 0;
    stray_rows    = 0;
    cycles        = 0;
    build_table();
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    // idle state before any input
    @(negedge clk);
    if (ready !== 1'b1 || out_valid !== 1'b0) begin
      $display("[FAIL] %0t test reset_state: ready/out_valid expected 1/0 got %b/%b", $time,
               ready, out_valid);
      failed++;
    end else begin
      $display("test reset_state: pass");
      passed++;
    end

    for (int t = 0; t < n_tests; t++) begin
      send_tile(t);
    end
    while (exp_rows.size() != 0) @(negedge clk);

    $display("tests passed %0d, failed %0d, stray rows %0d", passed, failed, stray_rows);
    if (failed == 0 && errors == 0 && stray_rows == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- matmul.f
common/matmul_pkg.sv
design/operand_skew.sv
systolic_array/processing_element.sv
systolic_array/systolic_array.sv
design/tile_sequencer.sv
design/result_buffer.sv
design/matmul_top.sv
dv/matmul_tb.sv

//--- Bender.yml
package:
  name: matmul

sources:
  - common/matmul_pkg.sv
  - design/operand_skew.sv
  - systolic_array/processing_element.sv
  - systolic_array/systolic_array.sv
  - design/tile_sequencer.sv
  - design/result_buffer.sv
  - design/matmul_top.sv
  - target: test
    files:
      - dv/matmul_tb.sv
